// File: Bender.yml
package:
  name: alu16

sources:
  # packages first, then the interface and the RTL
  - files:
      - hdl/aluDataPkg.sv
      - hdl/aluOpPkg.sv
      - hdl/aluOperandIf.sv
      - hdl/addSubUnit.sv
      - hdl/bitOpUnit.sv
      - hdl/resultStage.sv
      - hdl/aluTop.sv
  - target: test
    files:
      - verification/aluTb.sv

// File: hdl/addSubUnit.sv
/* ALU arithmetic unit */

`timescale 1ns/1ps

module addSubUnit
    import aluDataPkg::*, aluOpPkg::*;
#(
    parameter int DataWidth = DataWidthDefault
) (
    aluOperandIf.unit            opnd,
    output logic [DataWidth-1:0] arithResult,
    output logic                 arithOverflow
);

    localparam int Msb = DataWidth - 1;

    logic [DataWidth-1:0] sum;
    logic [DataWidth-1:0] diff;
    logic [DataWidth-1:0] incr;
    logic [DataWidth-1:0] decr;
    logic                 addOvf;
    logic                 subOvf;
    logic                 incOvf;
    logic                 decOvf;
    logic                 lte;

    // --------------------
    // raw results
    assign sum  = opnd.a + opnd.b;
    assign diff = opnd.a - opnd.b;
    assign incr = opnd.a + DataWidth'(1);
    assign decr = opnd.a - DataWidth'(1);

    // --------------------
    // signed overflow
    // same-sign operands, result sign flipped
    assign addOvf = (opnd.a[Msb] == opnd.b[Msb]) && (sum[Msb] != opnd.a[Msb]);
    // opposite-sign operands, result takes the sign of b
    assign subOvf = (opnd.a[Msb] != opnd.b[Msb]) && (diff[Msb] != opnd.a[Msb]);
    // only the largest positive value wraps
    assign incOvf = !opnd.a[Msb] && incr[Msb];
    // only the most negative value wraps
    assign decOvf = opnd.a[Msb] && !decr[Msb];

    // true sign of a-b is the result sign corrected by overflow
    assign lte = (diff[Msb] ^ subOvf) || (diff == '0);

    always_comb begin
        arithResult   = '0;
        arithOverflow = 1'b0;
        case (opnd.ctrl.op)
            OpSub: begin
                arithResult   = diff;
                arithOverflow = subOvf;
            end
            OpAdd: begin
                arithResult   = sum;
                arithOverflow = addOvf;
            end
            OpDec: begin
                arithResult   = decr;
                arithOverflow = decOvf;
            end
            OpInc: begin
                arithResult   = incr;
                arithOverflow = incOvf;
            end
            OpSlte: begin
                arithResult = {{(DataWidth-1){1'b0}}, lte};
            end
            default: begin
                arithResult   = '0;
                arithOverflow = 1'b0;
            end
        endcase
    end

endmodule

// File: hdl/aluDataPkg.sv
/* ALU data word definitions */

package aluDataPkg;

    // default datapath width
    localparam int DataWidthDefault = 16;

    // one ALU operand or result word
    typedef logic [DataWidthDefault-1:0] aluWord_t;

endpackage

// File: hdl/aluOpPkg.sv
/* ALU opcode definitions */

package aluOpPkg;

    // --------------------
    // opcodes
    typedef enum logic [3:0] {
        OpSub  = 4'b0000,
        OpAdd  = 4'b0001,
        OpOr   = 4'b0010,
        OpAnd  = 4'b0011,
        OpDec  = 4'b0100,
        OpInc  = 4'b0101,
        OpInv  = 4'b0110,
        OpShl  = 4'b1000,
        OpSlte = 4'b1001,
        OpShr  = 4'b1010,
        OpAsl  = 4'b1100,
        OpAsr  = 4'b1110
    } aluOp_e;

    // --------------------
    // shift view of the control word
    typedef struct packed {
        // set for the upper half of the opcode space
        logic isShift;
        logic arith;
        logic right;
        // compare and undefined codes
        logic odd;
    } shiftCtrl_t;

    // same four bits, two decodings
    typedef union packed {
        aluOp_e     op;
        shiftCtrl_t shift;
    } aluCtrl_u;

endpackage

// File: hdl/aluOperandIf.sv
/* ALU operand bundle */

`timescale 1ns/1ps

interface aluOperandIf
    import aluDataPkg::*, aluOpPkg::*;
#(
    parameter int DataWidth = DataWidthDefault
);

    logic [DataWidth-1:0] a;
    logic [DataWidth-1:0] b;
    aluCtrl_u             ctrl;
    logic                 valid;

    // combinational units only see the operation
    modport unit (
        input a,
        input b,
        input ctrl
    );

    // output register needs the opcode and the qualifier
    modport stage (
        input ctrl,
        input valid
    );

endinterface

// File: hdl/aluTop.sv
/* Pipelined 16-bit ALU */

`timescale 1ns/1ps

module aluTop
    import aluDataPkg::*, aluOpPkg::*;
#(
    parameter int DataWidth = $bits(aluWord_t)
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 inValid,
    input  logic [DataWidth-1:0] a,
    input  logic [DataWidth-1:0] b,
    input  logic [3:0]           aluCtrl,
    output logic                 outValid,
    output logic [DataWidth-1:0] s,
    output logic                 overflow,
    output logic                 zero
);

    logic [DataWidth-1:0] arithResult;
    logic                 arithOverflow;
    logic [DataWidth-1:0] bitResult;
    logic                 bitOverflow;

    aluOperandIf #(.DataWidth(DataWidth)) opnd ();

    assign opnd.a     = a;
    assign opnd.b     = b;
    assign opnd.ctrl  = aluCtrl_u'(aluCtrl);
    assign opnd.valid = inValid;

    // --------------------
    // units
    addSubUnit #(.DataWidth(DataWidth)) addSub0 (
        .opnd          (opnd.unit),
        .arithResult   (arithResult),
        .arithOverflow (arithOverflow)
    );

    bitOpUnit #(.DataWidth(DataWidth)) bitOp0 (
        .opnd        (opnd.unit),
        .bitResult   (bitResult),
        .bitOverflow (bitOverflow)
    );

    resultStage #(.DataWidth(DataWidth)) result0 (
        .clk           (clk),
        .rst           (rst),
        .opnd          (opnd.stage),
        .arithResult   (arithResult),
        .arithOverflow (arithOverflow),
        .bitResult     (bitResult),
        .bitOverflow   (bitOverflow),
        .outValid      (outValid),
        .s             (s),
        .overflow      (overflow),
        .zero          (zero)
    );

endmodule

// File: hdl/bitOpUnit.sv
/* ALU logic and shift unit */

`timescale 1ns/1ps

module bitOpUnit
    import aluDataPkg::*, aluOpPkg::*;
#(
    parameter int DataWidth = DataWidthDefault
) (
    aluOperandIf.unit            opnd,
    output logic [DataWidth-1:0] bitResult,
    output logic                 bitOverflow
);

    localparam int Msb = DataWidth - 1;

    logic [DataWidth-1:0] shifted;
    logic [DataWidth-1:0] logicResult;
    logic                 isShiftOp;
    logic                 fillBit;
    logic                 aslOvf;

    // --------------------
    // shifts by one, decoded from the shift view
    // odd codes in the shift half are compare or undefined
    assign isShiftOp = opnd.ctrl.shift.isShift && !opnd.ctrl.shift.odd;

    // sign fill only for arithmetic right
    assign fillBit = opnd.ctrl.shift.arith & opnd.a[Msb];

    assign shifted = opnd.ctrl.shift.right ? {fillBit, opnd.a[Msb:1]}
                                           : {opnd.a[Msb-1:0], 1'b0};

    // left shift changes sign when the top two bits differ
    assign aslOvf = opnd.ctrl.shift.arith && !opnd.ctrl.shift.right
                    && (opnd.a[Msb] ^ opnd.a[Msb-1]);

    // --------------------
    // bitwise ops, decoded from the op view
    always_comb begin
        case (opnd.ctrl.op)
            OpOr: begin
                logicResult = opnd.a | opnd.b;
            end
            OpAnd: begin
                logicResult = opnd.a & opnd.b;
            end
            OpInv: begin
                logicResult = ~opnd.a;
            end
            default: begin
                logicResult = '0;
            end
        endcase
    end

    always_comb begin
        if (isShiftOp) begin
            bitResult   = shifted;
            bitOverflow = aslOvf;
        end else begin
            bitResult   = logicResult;
            bitOverflow = 1'b0;
        end
    end

endmodule

// File: hdl/resultStage.sv
/* ALU result select and register */

`timescale 1ns/1ps

module resultStage
    import aluDataPkg::*, aluOpPkg::*;
#(
    parameter int DataWidth = DataWidthDefault
) (
    input  logic                 clk,
    input  logic                 rst,
    aluOperandIf.stage           opnd,
    input  logic [DataWidth-1:0] arithResult,
    input  logic                 arithOverflow,
    input  logic [DataWidth-1:0] bitResult,
    input  logic                 bitOverflow,
    output logic                 outValid,
    output logic [DataWidth-1:0] s,
    output logic                 overflow,
    output logic                 zero
);

    logic [DataWidth-1:0] selResult;
    logic                 selOverflow;
    logic                 selZero;

    // --------------------
    // unit select
    always_comb begin
        case (opnd.ctrl.op)
            OpSub, OpAdd, OpDec, OpInc, OpSlte: begin
                selResult   = arithResult;
                selOverflow = arithOverflow;
            end
            OpOr, OpAnd, OpInv, OpShl, OpShr, OpAsl, OpAsr: begin
                selResult   = bitResult;
                selOverflow = bitOverflow;
            end
            // 0111, 1011, 1101, 1111
            default: begin
                selResult   = '0;
                selOverflow = 1'b0;
            end
        endcase
    end

    assign selZero = (selResult == '0);

    // --------------------
    // output register
    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
            s        <= '0;
            overflow <= 1'b0;
            zero     <= 1'b0;
        end else begin
            outValid <= opnd.valid;
            // hold last result across idle cycles
            if (opnd.valid) begin
                s        <= selResult;
                overflow <= selOverflow;
                zero     <= selZero;
            end
        end
    end

endmodule

// File: sim.f
hdl/aluDataPkg.sv
hdl/aluOpPkg.sv
hdl/aluOperandIf.sv
hdl/addSubUnit.sv
hdl/bitOpUnit.sv
hdl/resultStage.sv
hdl/aluTop.sv
verification/aluTb.sv

// File: verification/aluTb.sv
/* ALU testbench */

`timescale 1ns/1ps

module aluTb
    import aluDataPkg::*, aluOpPkg::*;
();

    localparam int W = $bits(aluWord_t);
    localparam int MaxSigned = 2 ** (W - 1) - 1;
    localparam int MinSigned = -(2 ** (W - 1));
    localparam int unsigned Seed = 32'h2fce_d832;
    localparam int RandomOps = 2000;
    // about 2300 cycles of stimulus and gaps plus margin
    localparam int CycleLimit = 3000;

    typedef struct packed {
        logic [3:0] op;
        aluWord_t   x;
        aluWord_t   y;
    } opRec_t;

    logic       clk;
    logic       rst;
    logic       inValid;
    aluWord_t   a;
    aluWord_t   b;
    logic [3:0] aluCtrl;
    logic       outValid;
    aluWord_t   s;
    logic       overflow;
    logic       zero;

    opRec_t      opQueue[$];
    int          valueErrors = 0;
    int          otherErrors = 0;
    int          cycles = 0;
    logic        expValid = 1'b0;
    aluWord_t    heldS = '0;
    logic        heldOvf = 1'b0;
    logic        heldZero = 1'b0;

    aluTop #(.DataWidth(W)) dut0 (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .a        (a),
        .b        (b),
        .aluCtrl  (aluCtrl),
        .outValid (outValid),
        .s        (s),
        .overflow (overflow),
        .zero     (zero)
    );

    always #2 clk = ~clk;

    // --------------------
    // expected {overflow, s}
    function automatic logic [W:0] refAlu(input logic [3:0] op, input aluWord_t x,
                                          input aluWord_t y);
        int       sx;
        int       sy;
        int       full;
        aluWord_t res;
        logic     ovf;
        sx   = $signed(x);
        sy   = $signed(y);
        full = 0;
        res  = '0;
        ovf  = 1'b0;
        case (op)
            OpSub, OpAdd, OpDec, OpInc: begin
                if (op == OpSub) full = sx - sy;
                else if (op == OpAdd) full = sx + sy;
                else if (op == OpDec) full = sx - 1;
                else full = sx + 1;
                res = aluWord_t'(full);
                ovf = (full > MaxSigned) || (full < MinSigned);
            end
            OpOr:   res = x | y;
            OpAnd:  res = x & y;
            OpInv:  res = ~x;
            OpShl:  res = x << 1;
            OpShr:  res = x >> 1;
            OpAsr:  res = aluWord_t'($signed(x) >>> 1);
            OpAsl: begin
                res = x << 1;
                ovf = x[W-1] ^ x[W-2];
            end
            OpSlte: res = (sx <= sy) ? aluWord_t'(1) : '0;
            default: res = '0;
        endcase
        return {ovf, res};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            valueErrors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic reportCounts();
        $display("errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
    endtask

    // --------------------
    // compare process
    always @(posedge clk) begin
        opRec_t     rec;
        logic [W:0] exp;
        if (rst) begin
            expValid = 1'b0;
        end else begin
            checkValue("outValid", outValid, expValid);
            if (outValid && opQueue.size() == 0) begin
                otherErrors++;
                $display("outValid went high at %0t with no operation pending", $time);
            end else if (outValid) begin
                rec      = opQueue.pop_front();
                exp      = refAlu(rec.op, rec.x, rec.y);
                heldS    = exp[W-1:0];
                heldOvf  = exp[W];
                heldZero = (exp[W-1:0] == '0);
            end
            // idle cycles must hold the last result
            checkValue("s", s, heldS);
            checkValue("overflow", overflow, heldOvf);
            checkValue("zero", zero, heldZero);
            expValid = inValid;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", CycleLimit);
            reportCounts();
            $display("TEST FAIL");
            $finish;
        end
    end

    // --------------------
    // stimulus
    task automatic issueOp(input logic [3:0] op, input aluWord_t x, input aluWord_t y);
        opRec_t rec;
        @(negedge clk);
        inValid = 1'b1;
        a       = x;
        b       = y;
        aluCtrl = op;
        rec.op  = op;
        rec.x   = x;
        rec.y   = y;
        opQueue.push_back(rec);
    endtask

    task automatic idleCycle();
        @(negedge clk);
        inValid = 1'b0;
    endtask

    initial begin
        aluWord_t edgeVals[4];
        clk      = 1'b0;
        rst      = 1'b1;
        inValid  = 1'b0;
        a        = '0;
        b        = '0;
        aluCtrl  = '0;
        void'($urandom(Seed));
        edgeVals = '{16'h7fff, 16'h8000, 16'hffff, 16'h0000};
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (3) idleCycle();

        // add and subtract
        issueOp(OpAdd, 16'h7fff, 16'h0001);
        issueOp(OpSub, 16'h8000, 16'h0001);
        issueOp(OpAdd, 16'h8000, 16'h8000);
        issueOp(OpSub, 16'h0000, 16'h0000);
        idleCycle();
        // increment and decrement
        foreach (edgeVals[i]) begin
            issueOp(OpInc, edgeVals[i], aluWord_t'($urandom));
            issueOp(OpDec, edgeVals[i], aluWord_t'($urandom));
        end
        // bitwise
        issueOp(OpOr, aluWord_t'($urandom), aluWord_t'($urandom));
        issueOp(OpAnd, aluWord_t'($urandom), 16'hffff);
        issueOp(OpOr, 16'hffff, aluWord_t'($urandom));
        issueOp(OpInv, 16'hffff, 16'h0000);
        issueOp(OpInv, aluWord_t'($urandom), 16'h0000);
        idleCycle();
        idleCycle();
        // shifts
        foreach (edgeVals[i]) begin
            issueOp(OpShl, i < 2 ? 16'h4000 << i : aluWord_t'($urandom), '0);
            issueOp(OpShr, i < 2 ? 16'h4000 << i : aluWord_t'($urandom), '0);
            issueOp(OpAsl, i < 2 ? 16'h4000 << i : aluWord_t'($urandom), '0);
            issueOp(OpAsr, i < 2 ? 16'h4000 << i : aluWord_t'($urandom), '0);
        end
        // signed compare
        issueOp(OpSlte, 16'h8000, 16'h0001);
        issueOp(OpSlte, 16'h0001, 16'h8000);
        issueOp(OpSlte, 16'h1234, 16'h1234);
        issueOp(OpSlte, 16'hffff, 16'h0000);
        // undefined codes
        issueOp(4'b0111, aluWord_t'($urandom), aluWord_t'($urandom));
        issueOp(4'b1011, aluWord_t'($urandom), aluWord_t'($urandom));
        idleCycle();
        issueOp(4'b1101, aluWord_t'($urandom), aluWord_t'($urandom));
        issueOp(4'b1111, aluWord_t'($urandom), aluWord_t'($urandom));

        for (int i = 0; i < RandomOps; i++) begin
            issueOp(4'($urandom_range(15, 0)), aluWord_t'($urandom), aluWord_t'($urandom));
            if ($urandom_range(7, 0) == 0) begin
                idleCycle();
            end
        end
        idleCycle();
        // one-cycle latency drains the last operation
        repeat (2) @(posedge clk);
        if (opQueue.size() != 0) begin
            otherErrors++;
            $display("%0d operations never produced a result", opQueue.size());
        end
        reportCounts();
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
